//--- filelist.f
hdl/memsec_pkg.sv
hdl/access_decision_fifo.sv
hdl/mem_access_gate.sv
hdl/mem_bank.sv
hdl/secure_mem_top.sv
tb/secure_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the secure memory port testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f filelist.f --top-module secure_mem_tb \
	-Mdir "$BUILD_DIR" -o secure_mem_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/secure_mem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0

//--- tb/secure_mem_tb.sv
/*
 * secure memory port testbench: directed and random traffic against a
 * reference model, responses checked in request order
 */
`timescale 1ns/1ps

module secure_mem_tb;

	localparam int REQ_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int RAND_REQS     = 300;

	logic                                 clk;
	logic                                 reset;
	memsec_pkg::sec_level_t               bank_level;
	logic                                 net_req_val;
	logic                                 net_req_rdy;
	memsec_pkg::mem_type_e                net_req_type;
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  net_req_opaque;
	logic [memsec_pkg::ADDR_NBITS-1:0]    net_req_addr;
	logic [memsec_pkg::DATA_NBITS-1:0]    net_req_data;
	memsec_pkg::sec_level_t               net_req_level;
	logic                                 net_resp_val;
	logic                                 net_resp_rdy;
	memsec_pkg::mem_type_e                net_resp_type;
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  net_resp_opaque;
	memsec_pkg::resp_payload_u            net_resp_payload;

	// model memory and expected responses with the oldest first
	logic [memsec_pkg::DATA_NBITS-1:0]    model_mem [memsec_pkg::BANK_WORDS];
	memsec_pkg::mem_type_e                exp_type_q [$];
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  exp_opaque_q [$];
	memsec_pkg::resp_payload_u            exp_payload_q [$];

	int          mismatches;
	int          timeouts;
	int          req_count;
	int          resp_count;
	int          max_in_flight;
	logic        rdy_random;
	logic [31:0] stim_rng;
	logic [31:0] rdy_rng;

	secure_mem_top dut (
		.clk              (clk),
		.reset            (reset),
		.bank_level       (bank_level),
		.net_req_val      (net_req_val),
		.net_req_rdy      (net_req_rdy),
		.net_req_type     (net_req_type),
		.net_req_opaque   (net_req_opaque),
		.net_req_addr     (net_req_addr),
		.net_req_data     (net_req_data),
		.net_req_level    (net_req_level),
		.net_resp_val     (net_resp_val),
		.net_resp_rdy     (net_resp_rdy),
		.net_resp_type    (net_resp_type),
		.net_resp_opaque  (net_resp_opaque),
		.net_resp_payload (net_resp_payload)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// fill pattern built from the whole address
	function automatic logic [31:0] fill_word(input logic [15:0] addr);
		return {addr ^ 16'hc3a5, ~addr};
	endfunction

	// ========================================
	// reference model
	// ========================================

	// a level at or above the bank level is allowed and a lower one gets a fault record
	function automatic memsec_pkg::resp_payload_u ref_response(
		input  memsec_pkg::mem_type_e              req_type,
		input  logic [memsec_pkg::ADDR_NBITS-1:0]  addr,
		input  logic [memsec_pkg::DATA_NBITS-1:0]  data,
		input  memsec_pkg::sec_level_t             level,
		output memsec_pkg::mem_type_e              rsp_type
	);
		memsec_pkg::resp_payload_u p;
		p = '0;
		if (level < bank_level) begin
			rsp_type = memsec_pkg::MEM_DENIED;
			p.fault.required_level = bank_level;
			p.fault.request_level  = level;
			p.fault.addr           = addr;
		end else if (req_type == memsec_pkg::MEM_WRITE) begin
			// write ack carries zero data
			rsp_type = memsec_pkg::MEM_WRITE;
			model_mem[addr[memsec_pkg::BANK_IDX_NBITS-1:0]] = data;
		end else begin
			rsp_type = memsec_pkg::MEM_READ;
			p.data   = model_mem[addr[memsec_pkg::BANK_IDX_NBITS-1:0]];
		end
		return p;
	endfunction

	// ========================================
	// compare tasks
	// ========================================

	task automatic check_fault(
		input memsec_pkg::fault_rec_t exp_fault,
		input memsec_pkg::fault_rec_t got_fault
	);
		if (got_fault !== exp_fault) begin
			$display("Error at %0t: fault record %0d %0d %h pad %h, expected %0d %0d %h",
				$time, got_fault.required_level, got_fault.request_level, got_fault.addr,
				got_fault.zero, exp_fault.required_level, exp_fault.request_level, exp_fault.addr);
			mismatches++;
		end
	endtask

	task automatic check_resp(
		input memsec_pkg::mem_type_e               exp_type,
		input logic [memsec_pkg::OPAQUE_NBITS-1:0] exp_opaque,
		input memsec_pkg::resp_payload_u           exp_payload,
		input memsec_pkg::mem_type_e               got_type,
		input logic [memsec_pkg::OPAQUE_NBITS-1:0] got_opaque,
		input memsec_pkg::resp_payload_u           got_payload
	);
		if (got_type !== exp_type || got_opaque !== exp_opaque) begin
			$display("Error at %0t: response %s tag %h, expected %s tag %h",
				$time, got_type.name(), got_opaque, exp_type.name(), exp_opaque);
			mismatches++;
		end else if (exp_type == memsec_pkg::MEM_DENIED) begin
			check_fault(exp_payload.fault, got_payload.fault);
		end else if (got_payload.data !== exp_payload.data) begin
			$display("Error at %0t: tag %h data %h, expected %h",
				$time, got_opaque, got_payload.data, exp_payload.data);
			mismatches++;
		end
	endtask

	// ========================================
	// monitor and compare process
	// ========================================

	always @(posedge clk) begin : monitor
		memsec_pkg::mem_type_e     t;
		memsec_pkg::resp_payload_u p;
		if (!reset) begin
			// nothing may come back before the first request
			if (net_resp_val === 1'b1 && req_count == 0) begin
				$display("Error at %0t: response valid before any request", $time);
				mismatches++;
			end
			// pop before push since a response always belongs to an older request
			if (net_resp_val && net_resp_rdy) begin
				resp_count++;
				if (exp_type_q.size() == 0) begin
					$display("Error at %0t: response with no request outstanding", $time);
					mismatches++;
				end else begin
					check_resp(exp_type_q.pop_front(), exp_opaque_q.pop_front(),
						exp_payload_q.pop_front(), net_resp_type, net_resp_opaque,
						net_resp_payload);
				end
			end
			if (net_req_val && net_req_rdy) begin
				req_count++;
				p = ref_response(net_req_type, net_req_addr, net_req_data, net_req_level, t);
				exp_type_q.push_back(t);
				exp_opaque_q.push_back(net_req_opaque);
				exp_payload_q.push_back(p);
				if (exp_type_q.size() > max_in_flight)
					max_in_flight = exp_type_q.size();
			end
		end
	end

	// random response back-pressure about half the time when enabled
	always @(posedge clk) begin
		if (rdy_random) begin
			rdy_rng = xorshift32(rdy_rng);
			net_resp_rdy <= rdy_rng[9];
		end else begin
			net_resp_rdy <= 1'b1;
		end
	end

	// ========================================
	// stimulus helpers
	// ========================================

	// drive one request and hold it until the DUT takes it
	task automatic send_req(
		input memsec_pkg::mem_type_e               req_type,
		input logic [memsec_pkg::OPAQUE_NBITS-1:0] opaque,
		input logic [memsec_pkg::ADDR_NBITS-1:0]   addr,
		input logic [memsec_pkg::DATA_NBITS-1:0]   data,
		input memsec_pkg::sec_level_t              level
	);
		int waited;
		waited = 0;
		net_req_val    <= 1'b1;
		net_req_type   <= req_type;
		net_req_opaque <= opaque;
		net_req_addr   <= addr;
		net_req_data   <= data;
		net_req_level  <= level;
		@(posedge clk);
		while (net_req_rdy !== 1'b1 && waited < REQ_TIMEOUT) begin
			waited++;
			@(posedge clk);
		end
		if (net_req_rdy !== 1'b1) begin
			$display("Timeout: request tag %h was not accepted within %0d cycles",
				opaque, REQ_TIMEOUT);
			timeouts++;
		end
	endtask

	task automatic release_req();
		net_req_val <= 1'b0;
	endtask

	// wait until every expected response has come back
	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (exp_type_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (exp_type_q.size() != 0) begin
			$display("Timeout: %0d responses still missing after %0d cycles",
				exp_type_q.size(), DRAIN_TIMEOUT);
			timeouts++;
		end
		@(posedge clk);
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin : stimulus
		logic [31:0] r;
		int          i;
		clk            = 1'b0;
		reset          = 1'b1;
		bank_level     = 2'd0;
		net_req_val    = 1'b0;
		net_req_type   = memsec_pkg::MEM_READ;
		net_req_opaque = '0;
		net_req_addr   = '0;
		net_req_data   = '0;
		net_req_level  = 2'd0;
		net_resp_rdy   = 1'b1;
		rdy_random     = 1'b0;
		mismatches     = 0;
		timeouts       = 0;
		req_count      = 0;
		resp_count     = 0;
		max_in_flight  = 0;
		stim_rng       = 32'he2ad1eda;
		rdy_rng        = xorshift32(32'he2ad1eda);

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// idle for a while so the monitor can flag any early response
		repeat (3) @(posedge clk);

		// fill every word with the bank open and read a spread back
		for (i = 0; i < memsec_pkg::BANK_WORDS; i++)
			send_req(memsec_pkg::MEM_WRITE, 8'(i), 16'(i), fill_word(16'(i)), 2'd0);
		for (i = 0; i < 16; i++)
			send_req(memsec_pkg::MEM_READ, 8'(i + 100), 16'(i * 17), 32'h0, 2'd0);
		release_req();
		wait_drain();

		// lone read into an idle port answers one cycle after acceptance
		send_req(memsec_pkg::MEM_READ, 8'hee, 16'h0042, 32'h0, 2'd1);
		release_req();
		@(posedge clk);
		if (net_resp_val !== 1'b1) begin
			$display("Error at %0t: lone read response not valid one cycle after acceptance",
				$time);
			mismatches++;
		end
		wait_drain();

		// raise the bank level so low requesters get denied
		bank_level <= 2'd2;
		@(posedge clk);
		send_req(memsec_pkg::MEM_WRITE, 8'h20, 16'h0310, 32'hdeadbeef, 2'd1);
		send_req(memsec_pkg::MEM_READ, 8'h21, 16'h0310, 32'h0, 2'd1);
		// trusted read shows the denied write did not land
		send_req(memsec_pkg::MEM_READ, 8'h22, 16'h0310, 32'h0, 2'd3);
		send_req(memsec_pkg::MEM_READ, 8'h23, 16'h0011, 32'h0, 2'd2);
		release_req();
		wait_drain();

		// random mix back to back and again under back-pressure
		for (i = 0; i < 2 * RAND_REQS; i++) begin
			if (i == RAND_REQS)
				rdy_random <= 1'b1;
			stim_rng = xorshift32(stim_rng);
			r        = stim_rng;
			send_req(r[0] ? memsec_pkg::MEM_WRITE : memsec_pkg::MEM_READ, 8'(i),
				r[31:16], xorshift32(r), r[3:2]);
		end
		release_req();
		rdy_random <= 1'b0;
		wait_drain();

		if (max_in_flight < 2) begin
			$display("Error at %0t: never more than one request in flight", $time);
			mismatches++;
		end
		// every accepted request gets exactly one response
		if (resp_count != req_count) begin
			$display("Error at %0t: %0d responses for %0d requests",
				$time, resp_count, req_count);
			mismatches++;
		end
		$display("requests %0d, responses %0d, mismatches %0d, timeouts %0d",
			req_count, resp_count, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- hdl/secure_mem_top.sv
/*
 * secure memory port: access gate in front of a single memory bank
 */
`timescale 1ns/1ps

module secure_mem_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  memsec_pkg::sec_level_t               bank_level,

	// network request
	input  logic                                 net_req_val,
	output logic                                 net_req_rdy,
	input  memsec_pkg::mem_type_e                net_req_type,
	input  logic [memsec_pkg::OPAQUE_NBITS-1:0]  net_req_opaque,
	input  logic [memsec_pkg::ADDR_NBITS-1:0]    net_req_addr,
	input  logic [memsec_pkg::DATA_NBITS-1:0]    net_req_data,
	input  memsec_pkg::sec_level_t               net_req_level,

	// network response
	output logic                                 net_resp_val,
	input  logic                                 net_resp_rdy,
	output memsec_pkg::mem_type_e                net_resp_type,
	output logic [memsec_pkg::OPAQUE_NBITS-1:0]  net_resp_opaque,
	output memsec_pkg::resp_payload_u            net_resp_payload
);

	// gate to bank request
	logic                                 mem_req_val;
	logic                                 mem_req_rdy;
	memsec_pkg::mem_type_e                mem_req_type;
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  mem_req_opaque;
	logic [memsec_pkg::ADDR_NBITS-1:0]    mem_req_addr;
	logic [memsec_pkg::DATA_NBITS-1:0]    mem_req_data;

	// bank to gate response
	logic                                 mem_resp_val;
	logic                                 mem_resp_rdy;
	memsec_pkg::mem_type_e                mem_resp_type;
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  mem_resp_opaque;
	logic [memsec_pkg::DATA_NBITS-1:0]    mem_resp_data;

	mem_access_gate u_gate (
		.clk              (clk),
		.reset            (reset),
		.bank_level       (bank_level),
		.net_req_val      (net_req_val),
		.net_req_rdy      (net_req_rdy),
		.net_req_type     (net_req_type),
		.net_req_opaque   (net_req_opaque),
		.net_req_addr     (net_req_addr),
		.net_req_data     (net_req_data),
		.net_req_level    (net_req_level),
		.net_resp_val     (net_resp_val),
		.net_resp_rdy     (net_resp_rdy),
		.net_resp_type    (net_resp_type),
		.net_resp_opaque  (net_resp_opaque),
		.net_resp_payload (net_resp_payload),
		.mem_req_val      (mem_req_val),
		.mem_req_rdy      (mem_req_rdy),
		.mem_req_type     (mem_req_type),
		.mem_req_opaque   (mem_req_opaque),
		.mem_req_addr     (mem_req_addr),
		.mem_req_data     (mem_req_data),
		.mem_resp_val     (mem_resp_val),
		.mem_resp_rdy     (mem_resp_rdy),
		.mem_resp_type    (mem_resp_type),
		.mem_resp_opaque  (mem_resp_opaque),
		.mem_resp_data    (mem_resp_data)
	);

	mem_bank u_bank (
		.clk         (clk),
		.reset       (reset),
		.req_val     (mem_req_val),
		.req_rdy     (mem_req_rdy),
		.req_type    (mem_req_type),
		.req_opaque  (mem_req_opaque),
		.req_addr    (mem_req_addr),
		.req_data    (mem_req_data),
		.resp_val    (mem_resp_val),
		.resp_rdy    (mem_resp_rdy),
		.resp_type   (mem_resp_type),
		.resp_opaque (mem_resp_opaque),
		.resp_data   (mem_resp_data)
	);

endmodule

//--- hdl/mem_bank.sv
/*
 * memory bank: word-addressed synchronous storage with a one-entry
 * response register, val/rdy on request and response
 */
`timescale 1ns/1ps

module mem_bank (
	input  logic                                 clk,
	input  logic                                 reset,

	// request
	input  logic                                 req_val,
	output logic                                 req_rdy,
	input  memsec_pkg::mem_type_e                req_type,
	input  logic [memsec_pkg::OPAQUE_NBITS-1:0]  req_opaque,
	input  logic [memsec_pkg::ADDR_NBITS-1:0]    req_addr,
	input  logic [memsec_pkg::DATA_NBITS-1:0]    req_data,

	// response
	output logic                                 resp_val,
	input  logic                                 resp_rdy,
	output memsec_pkg::mem_type_e                resp_type,
	output logic [memsec_pkg::OPAQUE_NBITS-1:0]  resp_opaque,
	output logic [memsec_pkg::DATA_NBITS-1:0]    resp_data
);

	// storage array, contents undefined after reset
	logic [memsec_pkg::DATA_NBITS-1:0] mem [memsec_pkg::BANK_WORDS];

	logic                                   req_go;
	logic                                   is_write;
	logic [memsec_pkg::BANK_IDX_NBITS-1:0]  idx;

	// upper address bits are not decoded
	assign idx      = req_addr[memsec_pkg::BANK_IDX_NBITS-1:0];
	assign is_write = (req_type == memsec_pkg::MEM_WRITE);

	// take a new request when the output slot is free or freeing now
	assign req_rdy = !resp_val || resp_rdy;
	assign req_go  = req_val && req_rdy;

	// ========================================
	// storage
	// ========================================

	always_ff @(posedge clk) begin
		if (req_go && is_write)
			mem[idx] <= req_data;
	end

	// ========================================
	// response register
	// ========================================

	always_ff @(posedge clk) begin
		if (reset)
			resp_val <= 1'b0;
		else if (req_go)
			resp_val <= 1'b1;
		else if (resp_rdy)
			resp_val <= 1'b0;
	end

	// payload holds while the consumer stalls
	always_ff @(posedge clk) begin
		if (req_go) begin
			resp_type   <= req_type;
			resp_opaque <= req_opaque;
			// write acks carry a zero data field
			if (is_write)
				resp_data <= '0;
			else
				resp_data <= mem[idx];
		end
	end

endmodule

//--- hdl/mem_access_gate.sv
/*
 * memory access gate: checks each request level against the bank level,
 * forwards allowed requests and answers denied ones itself, in order
 */
`timescale 1ns/1ps

module mem_access_gate (
	input  logic                                 clk,
	input  logic                                 reset,
	input  memsec_pkg::sec_level_t               bank_level,

	// network request
	input  logic                                 net_req_val,
	output logic                                 net_req_rdy,
	input  memsec_pkg::mem_type_e                net_req_type,
	input  logic [memsec_pkg::OPAQUE_NBITS-1:0]  net_req_opaque,
	input  logic [memsec_pkg::ADDR_NBITS-1:0]    net_req_addr,
	input  logic [memsec_pkg::DATA_NBITS-1:0]    net_req_data,
	input  memsec_pkg::sec_level_t               net_req_level,

	// network response
	output logic                                 net_resp_val,
	input  logic                                 net_resp_rdy,
	output memsec_pkg::mem_type_e                net_resp_type,
	output logic [memsec_pkg::OPAQUE_NBITS-1:0]  net_resp_opaque,
	output memsec_pkg::resp_payload_u            net_resp_payload,

	// bank request
	output logic                                 mem_req_val,
	input  logic                                 mem_req_rdy,
	output memsec_pkg::mem_type_e                mem_req_type,
	output logic [memsec_pkg::OPAQUE_NBITS-1:0]  mem_req_opaque,
	output logic [memsec_pkg::ADDR_NBITS-1:0]    mem_req_addr,
	output logic [memsec_pkg::DATA_NBITS-1:0]    mem_req_data,

	// bank response
	input  logic                                 mem_resp_val,
	output logic                                 mem_resp_rdy,
	input  memsec_pkg::mem_type_e                mem_resp_type,
	input  logic [memsec_pkg::OPAQUE_NBITS-1:0]  mem_resp_opaque,
	input  logic [memsec_pkg::DATA_NBITS-1:0]    mem_resp_data
);

	logic                                 req_allowed;
	logic                                 push;
	logic                                 pop;
	memsec_pkg::mem_type_e                push_type;
	memsec_pkg::fault_rec_t               req_fault;
	logic                                 dq_full;
	logic                                 dq_empty;
	logic                                 head_allowed;
	memsec_pkg::mem_type_e                head_type;
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  head_opaque;
	memsec_pkg::fault_rec_t               head_fault;

	// ========================================
	// request side
	// ========================================

	// equal level counts as trusted enough
	assign req_allowed = (net_req_level >= bank_level);

	// denied requests need only a queue slot, allowed ones need the bank too
	assign net_req_rdy = !dq_full && (!req_allowed || mem_req_rdy);
	assign push        = net_req_val && net_req_rdy;

	// only allowed requests ever reach the bank
	assign mem_req_val    = net_req_val && req_allowed && !dq_full;
	assign mem_req_type   = net_req_type;
	assign mem_req_opaque = net_req_opaque;
	assign mem_req_addr   = net_req_addr;
	assign mem_req_data   = net_req_data;

	// fault record kept for a denied request
	always_comb begin
		req_fault                = '0;
		req_fault.required_level = bank_level;
		req_fault.request_level  = net_req_level;
		req_fault.addr           = net_req_addr;
	end

	// a denied entry remembers the response type it will send
	always_comb begin
		if (req_allowed)
			push_type = net_req_type;
		else
			push_type = memsec_pkg::MEM_DENIED;
	end

	access_decision_fifo u_dfifo (
		.clk          (clk),
		.reset        (reset),
		.push         (push),
		.pop          (pop),
		.push_allowed (req_allowed),
		.push_type    (push_type),
		.push_opaque  (net_req_opaque),
		.push_fault   (req_fault),
		.full         (dq_full),
		.empty        (dq_empty),
		.head_allowed (head_allowed),
		.head_type    (head_type),
		.head_opaque  (head_opaque),
		.head_fault   (head_fault)
	);

	// ========================================
	// response side
	// ========================================

	// bank is drained only when its response is the oldest one
	assign mem_resp_rdy = !dq_empty && head_allowed && net_resp_rdy;

	// head decides who answers, keeps allowed and denied in order
	always_comb begin
		if (head_allowed) begin
			net_resp_val          = !dq_empty && mem_resp_val;
			net_resp_type         = mem_resp_type;
			net_resp_opaque       = mem_resp_opaque;
			net_resp_payload.data = mem_resp_data;
		end else begin
			// denial is ready as soon as it sits at the head
			net_resp_val           = !dq_empty;
			net_resp_type          = head_type;
			net_resp_opaque        = head_opaque;
			net_resp_payload.fault = head_fault;
		end
	end

	assign pop = net_resp_val && net_resp_rdy;

endmodule

//--- hdl/access_decision_fifo.sv
/*
 * access decision FIFO: in-order queue of one decision record per
 * accepted request, head record shown on the outputs
 */
`timescale 1ns/1ps

module access_decision_fifo (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 push,
	input  logic                                 pop,
	input  logic                                 push_allowed,
	input  memsec_pkg::mem_type_e                push_type,
	input  logic [memsec_pkg::OPAQUE_NBITS-1:0]  push_opaque,
	input  memsec_pkg::fault_rec_t               push_fault,
	output logic                                 full,
	output logic                                 empty,
	output logic                                 head_allowed,
	output memsec_pkg::mem_type_e                head_type,
	output logic [memsec_pkg::OPAQUE_NBITS-1:0]  head_opaque,
	output memsec_pkg::fault_rec_t               head_fault
);

	// record storage
	logic                                 allowed_q [memsec_pkg::DFIFO_DEPTH];
	memsec_pkg::mem_type_e                type_q    [memsec_pkg::DFIFO_DEPTH];
	logic [memsec_pkg::OPAQUE_NBITS-1:0]  opaque_q  [memsec_pkg::DFIFO_DEPTH];
	memsec_pkg::fault_rec_t               fault_q   [memsec_pkg::DFIFO_DEPTH];

	logic [memsec_pkg::DFIFO_PTR_NBITS-1:0] wr_ptr;
	logic [memsec_pkg::DFIFO_PTR_NBITS-1:0] rd_ptr;
	logic [memsec_pkg::DFIFO_CNT_NBITS-1:0] count;

	logic do_push;
	logic do_pop;

	assign full  = (count == memsec_pkg::DFIFO_CNT_NBITS'(memsec_pkg::DFIFO_DEPTH));
	assign empty = (count == '0);

	// overflow and underflow are simply ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// write the new record at the tail
	always_ff @(posedge clk) begin
		if (do_push) begin
			allowed_q[wr_ptr] <= push_allowed;
			type_q[wr_ptr]    <= push_type;
			opaque_q[wr_ptr]  <= push_opaque;
			fault_q[wr_ptr]   <= push_fault;
		end
	end

	// pointers wrap at the queue depth
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == memsec_pkg::DFIFO_PTR_NBITS'(memsec_pkg::DFIFO_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == memsec_pkg::DFIFO_PTR_NBITS'(memsec_pkg::DFIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// push and pop together leave the count alone
	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (do_push && !do_pop)
			count <= count + 1'b1;
		else if (do_pop && !do_push)
			count <= count - 1'b1;
	end

	// head record
	assign head_allowed = allowed_q[rd_ptr];
	assign head_type    = type_q[rd_ptr];
	assign head_opaque  = opaque_q[rd_ptr];
	assign head_fault   = fault_q[rd_ptr];

endmodule

//--- hdl/memsec_pkg.sv
/*
 * memsec package: message field widths, security level, message types
 * and the response payload word shared by the gate, bank and top
 */
package memsec_pkg;

	// ========================================
	// message field widths
	// ========================================

	// requester tag echoed back in every response
	localparam int OPAQUE_NBITS = 8;
	localparam int ADDR_NBITS   = 16;
	localparam int DATA_NBITS   = 32;

	// ========================================
	// bank and queue sizing
	// ========================================

	// bank decodes only the low address bits
	localparam int BANK_WORDS     = 256;
	localparam int BANK_IDX_NBITS = $clog2(BANK_WORDS);

	// decision queue depth bounds the requests in flight
	localparam int DFIFO_DEPTH     = 4;
	localparam int DFIFO_PTR_NBITS = $clog2(DFIFO_DEPTH);
	localparam int DFIFO_CNT_NBITS = $clog2(DFIFO_DEPTH + 1);

	// spare bits at the bottom of a fault record
	localparam int FAULT_PAD_NBITS = DATA_NBITS - ADDR_NBITS - 4;

	// ========================================
	// types
	// ========================================

	// higher value is more trusted
	typedef logic [1:0] sec_level_t;

	// requests carry read or write, denied only shows up in responses
	typedef enum logic [1:0] {
		MEM_READ   = 2'd0,
		MEM_WRITE  = 2'd1,
		MEM_DENIED = 2'd2
	} mem_type_e;

	// what a denied request gets back in place of data
	typedef struct packed {
		sec_level_t                   required_level;
		sec_level_t                   request_level;
		logic [ADDR_NBITS-1:0]        addr;
		logic [FAULT_PAD_NBITS-1:0]   zero;
	} fault_rec_t;

	// one response word, read data or fault record depending on the type
	typedef union packed {
		logic [DATA_NBITS-1:0] data;
		fault_rec_t            fault;
	} resp_payload_u;

endpackage
